//--- source/div_pkg.sv
package div_pkg;

   // operand and result width of the divider
   localparam int XLEN = 32;

   // RISC-V M-extension division opcodes
   typedef enum logic [1:0] {
      OP_DIV  = 2'b00,  // signed quotient
      OP_DIVU = 2'b01,  // unsigned quotient
      OP_REM  = 2'b10,  // signed remainder
      OP_REMU = 2'b11   // unsigned remainder
   } div_op_e;

   // controller FSM states
   typedef enum logic [1:0] {
      ST_IDLE = 2'b00,  // waiting for a start pulse
      ST_RUN  = 2'b01,  // core enabled, waiting for done
      ST_DONE = 2'b10   // result registered, valid pulse
   } div_state_e;

endpackage

//--- source/div_shift_sub.sv
`timescale 1ns/1ps

module div_shift_sub #(
   parameter int DATA_W = div_pkg::XLEN
) (
   input  logic              clk_i,
   input  logic              arst_n_i,
   input  logic              en_i,
   input  logic              sign_i,
   input  logic [DATA_W-1:0] dividend_i,
   input  logic [DATA_W-1:0] divisor_i,
   output logic              done_o,
   output logic [DATA_W-1:0] quotient_o,
   output logic [DATA_W-1:0] remainder_o
);

   localparam int STEP_W = $clog2(DATA_W + 5) + 1;

   localparam logic [STEP_W-1:0] STEP_LOAD  = STEP_W'(0);
   localparam logic [STEP_W-1:0] STEP_DMAG  = STEP_W'(1);
   localparam logic [STEP_W-1:0] STEP_QSIGN = STEP_W'(DATA_W + 2);
   localparam logic [STEP_W-1:0] STEP_RSIGN = STEP_W'(DATA_W + 3);
   localparam logic [STEP_W-1:0] STEP_LAST  = STEP_W'(DATA_W + 4);

   logic [2*DATA_W-1:0] rq_q;           // remainder in upper half, quotient in lower
   logic [DATA_W-1:0]   divisor_q;
   logic                dividend_neg_q;
   logic                divisor_neg_q;
   logic [STEP_W-1:0]   step_q;
   logic [DATA_W-1:0]   window;         // partial remainder with next dividend bit
   logic [DATA_W:0]     diff;           // msb is the borrow
   logic [DATA_W-1:0]   quot_mag;
   logic [DATA_W-1:0]   rem_mag;

   assign window   = rq_q[2*DATA_W-2 -: DATA_W];
   assign diff     = {1'b0, window} - {1'b0, divisor_q};
   assign quot_mag = rq_q[DATA_W-1:0];
   assign rem_mag  = rq_q[2*DATA_W-1 -: DATA_W];

   assign quotient_o  = quot_mag;
   assign remainder_o = rem_mag;

   // step counter and done flag, cleared whenever the enable drops
   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         step_q <= '0;
         done_o <= 1'b0;
      end else if (!en_i) begin
         step_q <= '0;
         done_o <= 1'b0;
      end else begin
         if (step_q != STEP_LAST) begin
            step_q <= step_q + 1'b1;
         end
         if (step_q == STEP_RSIGN) begin
            done_o <= 1'b1;                // remainder sign fixed this edge
         end
      end
   end

   // datapath, one action per step
   always_ff @(posedge clk_i) begin
      if (en_i) begin
         case (step_q)
            STEP_LOAD: begin
               dividend_neg_q <= sign_i & dividend_i[DATA_W-1];
               divisor_neg_q  <= sign_i & divisor_i[DATA_W-1];
               divisor_q      <= divisor_i;
               rq_q           <= {{DATA_W{1'b0}},
                                  (sign_i && dividend_i[DATA_W-1]) ? -dividend_i : dividend_i};
            end

            STEP_DMAG: begin
               if (divisor_neg_q) begin
                  divisor_q <= -divisor_q;     // divisor magnitude
               end
            end

            STEP_QSIGN: begin
               if (dividend_neg_q ^ divisor_neg_q) begin
                  rq_q[DATA_W-1:0] <= -quot_mag;
               end
            end

            STEP_RSIGN: begin
               // remainder follows the dividend sign
               if (dividend_neg_q) begin
                  rq_q[2*DATA_W-1 -: DATA_W] <= -rem_mag;
               end
            end

            STEP_LAST: begin
               rq_q <= rq_q;                   // result held
            end

            default: begin
               if (!diff[DATA_W]) begin
                  rq_q <= {diff[DATA_W-1:0], rq_q[DATA_W-2:0], 1'b1};  // fits, quotient bit 1
               end else begin
                  rq_q <= {rq_q[2*DATA_W-2:0], 1'b0};
               end
            end
         endcase
      end
   end

   // done can only follow an enabled edge
   a_done_needs_en : assert property (
      @(posedge clk_i) disable iff (!arst_n_i)
      !$past(en_i) |-> !done_o
   ) else $error("done_o high after an edge with en_i low");

   a_step_bound : assert property (
      @(posedge clk_i) disable iff (!arst_n_i)
      step_q <= STEP_LAST
   ) else $error("step counter ran past its final step");

endmodule

//--- source/div_ctrl.sv
`timescale 1ns/1ps

module div_ctrl (
   input  logic                       clk_i,
   input  logic                       arst_n_i,
   input  logic                       start_i,
   input  div_pkg::div_op_e           op_i,
   input  logic [div_pkg::XLEN-1:0]   dividend_i,
   input  logic [div_pkg::XLEN-1:0]   divisor_i,
   input  logic                       core_done_i,
   input  logic [div_pkg::XLEN-1:0]   core_quotient_i,
   input  logic [div_pkg::XLEN-1:0]   core_remainder_i,
   output logic                       busy_o,
   output logic                       valid_o,
   output logic                       core_en_o,
   output logic                       core_sign_o,
   output logic [div_pkg::XLEN-1:0]   core_dividend_o,
   output logic [div_pkg::XLEN-1:0]   core_divisor_o,
   output logic [div_pkg::XLEN-1:0]   result_o
);

   import div_pkg::*;

   div_state_e      state_q;
   div_op_e         op_q;
   logic [XLEN-1:0] dividend_q;
   logic [XLEN-1:0] divisor_q;
   logic [XLEN-1:0] result_q;
   logic            valid_q;
   logic            core_en_q;
   logic            accept;
   logic            div_zero;
   logic            sign_ovf;
   logic            special;
   logic [XLEN-1:0] special_result;

   function automatic logic op_signed(div_op_e op);
      return (op == OP_DIV) || (op == OP_REM);
   endfunction

   function automatic logic op_rem(div_op_e op);
      return (op == OP_REM) || (op == OP_REMU);
   endfunction

   assign accept = start_i && (state_q == ST_IDLE);

   // cases the core cannot answer on its own
   assign div_zero = (divisor_i == '0);
   assign sign_ovf = op_signed(op_i)
                     && (dividend_i == {1'b1, {(XLEN-1){1'b0}}})
                     && (divisor_i == '1);
   assign special  = div_zero || sign_ovf;

   always_comb begin
      if (div_zero) begin
         special_result = op_rem(op_i) ? dividend_i : '1;  // quotient all ones
      end else begin
         special_result = op_rem(op_i) ? '0 : dividend_i;  // overflow
      end
   end

   // command latch, stable while the core runs
   always_ff @(posedge clk_i) begin
      if (accept) begin
         op_q       <= op_i;
         dividend_q <= dividend_i;
         divisor_q  <= divisor_i;
      end
   end

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         state_q   <= ST_IDLE;
         valid_q   <= 1'b0;
         core_en_q <= 1'b0;
         result_q  <= '0;
      end else begin
         valid_q <= 1'b0;                      // one-cycle pulse
         case (state_q)
            ST_IDLE: begin
               if (start_i) begin
                  if (special) begin
                     state_q  <= ST_DONE;
                     valid_q  <= 1'b1;
                     result_q <= special_result;
                  end else begin
                     state_q   <= ST_RUN;
                     core_en_q <= 1'b1;
                  end
               end
            end

            ST_RUN: begin
               if (core_done_i) begin
                  state_q   <= ST_DONE;
                  core_en_q <= 1'b0;           // core clears on the next edge
                  valid_q   <= 1'b1;
                  result_q  <= op_rem(op_q) ? core_remainder_i : core_quotient_i;
               end
            end

            ST_DONE: state_q <= ST_IDLE;

            default: state_q <= ST_IDLE;
         endcase
      end
   end

   assign busy_o          = (state_q != ST_IDLE);
   assign valid_o         = valid_q;
   assign core_en_o       = core_en_q;
   assign core_sign_o     = op_signed(op_q);
   assign core_dividend_o = dividend_q;
   assign core_divisor_o  = divisor_q;
   assign result_o        = result_q;

   a_valid_single : assert property (
      @(posedge clk_i) disable iff (!arst_n_i)
      valid_o |=> !valid_o
   ) else $error("valid_o held for more than one cycle");

   // enable flop must track the FSM
   a_en_in_run : assert property (
      @(posedge clk_i) disable iff (!arst_n_i)
      core_en_o |-> (state_q == ST_RUN)
   ) else $error("core_en_o high outside ST_RUN");

endmodule

//--- source/div_unit.sv
`timescale 1ns/1ps

module div_unit (
   input  logic                     clk_i,
   input  logic                     arst_n_i,
   input  logic                     start_i,
   input  div_pkg::div_op_e         op_i,
   input  logic [div_pkg::XLEN-1:0] dividend_i,
   input  logic [div_pkg::XLEN-1:0] divisor_i,
   output logic                     busy_o,
   output logic                     valid_o,
   output logic [div_pkg::XLEN-1:0] result_o
);

   import div_pkg::*;

   logic            core_en;
   logic            core_sign;
   logic            core_done;
   logic [XLEN-1:0] core_dividend;
   logic [XLEN-1:0] core_divisor;
   logic [XLEN-1:0] core_quotient;
   logic [XLEN-1:0] core_remainder;

   div_ctrl div_ctrl_i (
      .clk_i            (clk_i),
      .arst_n_i         (arst_n_i),
      .start_i          (start_i),
      .op_i             (op_i),
      .dividend_i       (dividend_i),
      .divisor_i        (divisor_i),
      .core_done_i      (core_done),
      .core_quotient_i  (core_quotient),
      .core_remainder_i (core_remainder),
      .busy_o           (busy_o),
      .valid_o          (valid_o),
      .core_en_o        (core_en),
      .core_sign_o      (core_sign),
      .core_dividend_o  (core_dividend),
      .core_divisor_o   (core_divisor),
      .result_o         (result_o)
   );

   div_shift_sub #(
      .DATA_W (XLEN)
   ) div_shift_sub_i (
      .clk_i       (clk_i),
      .arst_n_i    (arst_n_i),
      .en_i        (core_en),
      .sign_i      (core_sign),
      .dividend_i  (core_dividend),
      .divisor_i   (core_divisor),
      .done_o      (core_done),
      .quotient_o  (core_quotient),
      .remainder_o (core_remainder)
   );

endmodule

//--- verification/div_unit_ref.svh
`ifndef DIV_UNIT_REF_SVH
`define DIV_UNIT_REF_SVH

// expected result word for one division command
function automatic logic [XLEN-1:0] ref_div(input div_op_e         op,
                                            input logic [XLEN-1:0] a,
                                            input logic [XLEN-1:0] b);
   logic            is_rem;
   logic            is_signed;
   logic [XLEN-1:0] min_neg;
   is_rem    = (op == OP_REM) || (op == OP_REMU);
   is_signed = (op == OP_DIV) || (op == OP_REM);
   min_neg   = {1'b1, {(XLEN-1){1'b0}}};
   if (b == '0) begin
      return is_rem ? a : '1;              // quotient all ones, remainder is dividend
   end
   if (is_signed && (a == min_neg) && (b == '1)) begin
      return is_rem ? '0 : a;              // signed overflow
   end
   if (is_signed) begin
      // truncates toward zero, remainder keeps the dividend sign
      if (is_rem) begin
         return $signed(a) % $signed(b);
      end
      return $signed(a) / $signed(b);
   end
   return is_rem ? (a % b) : (a / b);
endfunction

`endif

//--- verification/div_unit_tb.sv
`timescale 1ns/1ps

module div_unit_tb;

   import div_pkg::*;

   `include "div_unit_ref.svh"

   localparam int RESET_CYCLES    = 16;
   localparam int N_DIRECTED      = 29;
   localparam int N_RANDOM        = 200;
   localparam int N_CMDS          = N_DIRECTED + N_RANDOM;
   localparam int WATCHDOG_CYCLES = RESET_CYCLES + N_CMDS * (XLEN + 10);
   localparam logic [XLEN-1:0] MIN_NEG = {1'b1, {(XLEN-1){1'b0}}};

   logic            clk_i;
   logic            arst_n_i;
   logic            start_i;
   div_op_e         op_i;
   logic [XLEN-1:0] dividend_i;
   logic [XLEN-1:0] divisor_i;
   logic            busy_o;
   logic            valid_o;
   logic [XLEN-1:0] result_o;

   logic [XLEN-1:0] expect_q[$];       // results still owed by the DUT
   int              mismatch_cnt = 0;
   int              spurious_cnt = 0;
   int              other_cnt = 0;
   int              seed;

   div_unit div_unit_i (
      .clk_i      (clk_i),
      .arst_n_i   (arst_n_i),
      .start_i    (start_i),
      .op_i       (op_i),
      .dividend_i (dividend_i),
      .divisor_i  (divisor_i),
      .busy_o     (busy_o),
      .valid_o    (valid_o),
      .result_o   (result_o)
   );

   initial begin
      clk_i = 1'b0;
      forever #4 clk_i = ~clk_i;
   end

   task automatic wait_valid();
      do begin
         @(posedge clk_i);
      end while (!valid_o);
   endtask

   // waits for idle, then drives a one-cycle start
   task automatic send_start(input div_op_e op, input logic [XLEN-1:0] a,
                             input logic [XLEN-1:0] b);
      @(posedge clk_i);
      while (busy_o) begin
         @(posedge clk_i);
      end
      expect_q.push_back(ref_div(op, a, b));
      start_i    <= 1'b1;
      op_i       <= op;
      dividend_i <= a;
      divisor_i  <= b;
      @(posedge clk_i);
      start_i <= 1'b0;
   endtask

   task automatic issue(input div_op_e op, input logic [XLEN-1:0] a,
                        input logic [XLEN-1:0] b);
      send_start(op, a, b);
      wait_valid();
   endtask

   task automatic issue_pair(input div_op_e q_op, input div_op_e r_op,
                             input logic [XLEN-1:0] a, input logic [XLEN-1:0] b);
      issue(q_op, a, b);
      issue(r_op, a, b);
   endtask

   // second start lands mid-run and must be dropped
   task automatic start_while_busy(input logic [XLEN-1:0] a, input logic [XLEN-1:0] b);
      send_start(OP_DIVU, a, b);
      repeat (3) @(posedge clk_i);
      assert (busy_o) else begin
         $display("%0t: busy_o is low while a division is running", $time);
         other_cnt++;
      end
      start_i    <= 1'b1;
      op_i       <= OP_REMU;
      dividend_i <= ~a;
      divisor_i  <= b + 1'b1;
      @(posedge clk_i);
      start_i <= 1'b0;
      wait_valid();
      repeat (XLEN + 8) @(posedge clk_i);  // a second pulse would show as spurious
   endtask

   // compare process samples on the edge that ends the valid cycle
   always @(posedge clk_i) begin
      logic [XLEN-1:0] exp_val;
      if (arst_n_i && valid_o) begin
         assert (expect_q.size() > 0) else begin
            $display("%0t: valid_o pulsed with no command outstanding", $time);
            spurious_cnt++;
         end
         if (expect_q.size() > 0) begin
            exp_val = expect_q.pop_front();
            assert (result_o == exp_val) else begin
               $display("Mismatch at %0t: result_o expected %h, got %h",
                        $time, exp_val, result_o);
               mismatch_cnt++;
            end
         end
      end
   end

   initial begin
      repeat (WATCHDOG_CYCLES) @(posedge clk_i);
      $display("timeout: run did not finish within %0d cycles", WATCHDOG_CYCLES);
      $display("*** TEST FAILED ***");
      $finish;
   end

   initial begin
      logic [1:0]      op_bits;
      logic [4:0]      shift_bits;
      logic [XLEN-1:0] rnd_a;
      logic [XLEN-1:0] rnd_b;
      seed       = 54;
      arst_n_i   = 1'b0;
      start_i    = 1'b0;
      op_i       = OP_DIV;
      dividend_i = '0;
      divisor_i  = '0;
      repeat (RESET_CYCLES) @(posedge clk_i);
      arst_n_i <= 1'b1;
      repeat (4) begin
         @(posedge clk_i);
         assert (!valid_o && !busy_o && (result_o == '0)) else begin
            $display("%0t: outputs not idle after reset", $time);
            other_cnt++;
         end
      end

      // unsigned directed values
      issue_pair(OP_DIVU, OP_REMU, 32'd100, 32'd7);
      issue_pair(OP_DIVU, OP_REMU, 32'h8000_0000, 32'd3);
      issue_pair(OP_DIVU, OP_REMU, 32'hFFFF_FFFF, 32'h10);
      issue_pair(OP_DIVU, OP_REMU, 32'd5, 32'd9);
      issue_pair(OP_DIVU, OP_REMU, 32'h1234, 32'h1234);
      issue_pair(OP_DIVU, OP_REMU, 32'hFFFF_FFFF, 32'h8000_0001);

      // signed, all four sign combinations
      issue_pair(OP_DIV, OP_REM, 32'd100, 32'd7);
      issue_pair(OP_DIV, OP_REM, -32'd100, 32'd7);
      issue_pair(OP_DIV, OP_REM, 32'd100, -32'd7);
      issue_pair(OP_DIV, OP_REM, -32'd100, -32'd7);

      // divide by zero
      issue_pair(OP_DIV, OP_REM, 32'hDEAD_BEEF, '0);
      issue_pair(OP_DIVU, OP_REMU, 32'h0000_1234, '0);

      // most negative over minus one
      issue_pair(OP_DIV, OP_REM, MIN_NEG, '1);
      issue_pair(OP_DIVU, OP_REMU, MIN_NEG, '1);

      start_while_busy(32'd1000, 32'd33);

      for (int i = 0; i < N_RANDOM; i++) begin
         op_bits    = 2'($random(seed));
         rnd_a      = $random(seed);
         rnd_b      = $random(seed);
         shift_bits = 5'($random(seed));
         if (i % 2 == 1) begin
            rnd_b = rnd_b >> shift_bits;     // smaller divisors give longer quotients
         end
         issue(div_op_e'(op_bits), rnd_a, rnd_b);
      end

      repeat (4) @(posedge clk_i);
      $display("errors: mismatches %0d, unexpected valid %0d, other %0d",
               mismatch_cnt, spurious_cnt, other_cnt);
      if (mismatch_cnt + spurious_cnt + other_cnt == 0) begin
         $display("*** TEST PASSED ***");
      end else begin
         $display("*** TEST FAILED ***");
      end
      $finish;
   end

endmodule

//--- div_unit.f
+incdir+verification
source/div_pkg.sv
source/div_shift_sub.sv
source/div_ctrl.sv
source/div_unit.sv
verification/div_unit_tb.sv

//--- Bender.yml
package:
  name: div_unit

sources:
  - files:
      - source/div_pkg.sv
      - source/div_shift_sub.sv
      - source/div_ctrl.sv
      - source/div_unit.sv
  - target: test
    include_dirs:
      - verification
    files:
      - verification/div_unit_tb.sv
